/* verilog.f */
+incdir+include
rtl/vic_pkg.sv
rtl/vic_if.sv
rtl/beam_counter.sv
rtl/register_file.sv
rtl/video_timing.sv
rtl/vic_top.sv
testbench/tb_vic.sv

/* run.sh */
#!/bin/sh
# Builds the raster core testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_vic -o tb_vic

output=$(./obj_dir/tb_vic)
echo "$output"

# The run counts as good only if the testbench printed its pass line
echo "$output" | grep -q '^>>> PASS$'

/* include/tb_bus_tasks.svh */
// ==================================================
// CPU bus tasks and readback rules for the testbench.
// Included inside the testbench module, which must
// declare pixel_clock, cs, we, addr, data_in and
// data_out. Each access holds cs for 8 cycles so one
// access phase always falls inside it.
// ==================================================
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
    @(negedge pixel_clock);
    cs      = 1'b1;
    we      = 1'b1;
    addr    = a;
    data_in = d;
    repeat (8) @(negedge pixel_clock);
    cs = 1'b0;
    we = 1'b0;
endtask

task automatic bus_read(input logic [5:0] a, output logic [7:0] d);
    @(negedge pixel_clock);
    cs   = 1'b1;
    we   = 1'b0;
    addr = a;
    repeat (8) @(negedge pixel_clock);
    d  = data_out;     // Latched on the last access phase
    cs = 1'b0;
endtask

// What a plain register returns after a write of w
function automatic logic [7:0] expected_read(input logic [5:0] a, input logic [7:0] w);
    logic [7:0] forced_ones;
    forced_ones = 8'h00;
    if (a >= vic_pkg::reg_count) begin
        forced_ones = 8'hFF;          // Nothing mapped up here
    end else if (a >= vic_pkg::color_reg_first) begin
        forced_ones = 8'hF0;          // Only a color nibble is stored
    end else if (a == vic_pkg::reg_ctrl2) begin
        forced_ones = 8'hC0;
    end else if (a == vic_pkg::reg_irq_enable) begin
        forced_ones = 8'hF0;
    end
    return w | forced_ones;
endfunction

// Raster line one advance later
function automatic logic [8:0] next_line(input logic [8:0] l);
    return 9'((int'(l) + 1) % int'(vic_pkg::lines_per_frame));
endfunction

`endif

/* testbench/tb_vic.sv */
// ==================================================
// Testbench of the VIC-II style raster core.
// Drives the CPU bus on falling edges and checks
// phi0, register readback, the raster line and
// interrupt, sync and blank, and the display window.
// One line per test, then a summary line.
// ==================================================
`timescale 1ns/1ps

module tb_vic;

    localparam int clock_period  = 100;
    localparam int line_cycles   = int'(vic_pkg::pixels_per_line);
    localparam int frame_lines   = int'(vic_pkg::lines_per_frame);
    localparam int frame_cycles  = line_cycles * frame_lines;
    localparam int budget_frames = 9;      // Longest path through the tests is under 8 frames

    logic       pixel_clock;
    logic       reset;
    logic       cs;
    logic       we;
    logic [5:0] addr;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       irq;
    logic       phi0;
    logic [3:0] color;
    logic       sync;
    logic       blank;
    logic       phi0_armed;
    int         errors;
    int         checks;
    int         tests_done;

    `include "tb_bus_tasks.svh"

    vic_top DUT (
        .pixel_clock (pixel_clock),
        .reset       (reset),
        .cs          (cs),
        .we          (we),
        .addr        (addr),
        .data_in     (data_in),
        .data_out    (data_out),
        .irq         (irq),
        .phi0        (phi0),
        .color       (color),
        .sync        (sync),
        .blank       (blank)
    );

    initial begin
        pixel_clock = 1'b0;
        forever #(clock_period / 2) pixel_clock = ~pixel_clock;
    end

    initial begin : watchdog
        #(clock_period * (budget_frames * frame_cycles + 20000));
        $display("Watchdog expired, the tests did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

    // Four high, four low, so every level flips after four pixels
    phi0_period: assert property (@(posedge pixel_clock) disable iff (!phi0_armed)
        phi0 != $past(phi0, 4))
    else begin
        $display("FAIL t=%0t phi0 kept its level across 4 cycles", $time);
        errors++;
    end

    task automatic check_equal(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_done++;
        if (errors == errors_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d failed checks", name, errors - errors_before);
        end
    endtask

    // Cycles that phi0 stays at one level
    task automatic measure_run(input logic level, output int length);
        length = 0;
        while (phi0 === level) begin
            length++;
            @(negedge pixel_clock);
        end
    endtask

    // Retries until both low byte reads agree, so bit 8 belongs to the same line
    task automatic read_line(output logic [8:0] value);
        logic [7:0] low_first;
        logic [7:0] high;
        logic [7:0] low_second;
        do begin
            bus_read(vic_pkg::reg_raster, low_first);
            bus_read(vic_pkg::reg_ctrl1, high);
            bus_read(vic_pkg::reg_raster, low_second);
        end while (low_first != low_second);
        value = {high[7], low_second};
    endtask

    task automatic goto_line(input int target);
        logic [8:0] now;
        read_line(now);
        repeat (((target - int'(now) + frame_lines) % frame_lines) * line_cycles)
            @(negedge pixel_clock);
    endtask

    task automatic watch_outputs(input int cycles, input logic [3:0] bkg,
                                 output int sync_count, output int blank_count,
                                 output int bkg_count, output int irq_count,
                                 output int longest_blank);
        int run;
        sync_count    = 0;
        blank_count   = 0;
        bkg_count     = 0;
        irq_count     = 0;
        longest_blank = 0;
        run           = 0;
        repeat (cycles) begin
            @(negedge pixel_clock);
            if (sync) sync_count++;
            if (irq) irq_count++;
            if (color == bkg) bkg_count++;
            if (blank) begin
                blank_count++;
                run++;
                if (run > longest_blank) longest_blank = run;
            end else begin
                run = 0;
            end
        end
    endtask

    initial begin : stimulus
        logic [7:0] value;
        logic [7:0] got;
        logic [8:0] line_a;
        logic [8:0] line_b;
        logic [8:0] compare;
        logic [3:0] exterior;
        logic [3:0] background;
        int errors_before;
        int high_len;
        int low_len;
        int waited;
        int sync_count;
        int blank_count;
        int bkg_count;
        int irq_count;
        int longest;

        void'($urandom(1326));
        reset      = 1'b1;
        cs         = 1'b0;
        we         = 1'b0;
        addr       = '0;
        data_in    = '0;
        phi0_armed = 1'b0;
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        repeat (16) @(posedge pixel_clock);
        @(negedge pixel_clock);
        reset = 1'b0;

        errors_before = errors;
        repeat (8) @(negedge pixel_clock);
        phi0_armed = 1'b1;
        while (phi0 !== 1'b0) @(negedge pixel_clock);
        while (phi0 !== 1'b1) @(negedge pixel_clock);
        repeat (4) begin
            measure_run(1'b1, high_len);
            measure_run(1'b0, low_len);
            check_equal("phi0 high cycles", high_len, 4);
            check_equal("phi0 low cycles", low_len, 4);
        end
        report_test("phi0", errors_before);

        errors_before = errors;
        for (int a = 0; a < 64; a++) begin
            if (a == int'(vic_pkg::reg_ctrl1) || a == int'(vic_pkg::reg_raster)
                || a == int'(vic_pkg::reg_irq_latch)) begin
                continue;   // Live or self clearing
            end
            value = 8'($urandom);
            bus_write(6'(a), value);
            bus_read(6'(a), got);
            check_equal($sformatf("readback 0x%02h", a), got, expected_read(6'(a), value));
        end
        bus_write(vic_pkg::reg_irq_enable, 8'h00);
        bus_write(vic_pkg::reg_irq_latch, 8'h01);   // Drop any stray raster hit
        report_test("registers", errors_before);

        errors_before = errors;
        read_line(line_a);
        repeat (line_cycles - 27) @(negedge pixel_clock);  // Next read starts one line later
        read_line(line_b);
        check_equal("raster line step", line_b, next_line(line_a));
        report_test("raster readback", errors_before);

        errors_before = errors;
        compare = 9'($urandom % frame_lines);
        bus_write(vic_pkg::reg_raster, compare[7:0]);
        bus_write(vic_pkg::reg_ctrl1, {compare[8], 7'h18});
        check_equal("irq before enable", irq, 0);
        bus_write(vic_pkg::reg_irq_enable, 8'h01);
        waited = 0;
        while (irq !== 1'b1 && waited < frame_cycles + line_cycles) begin
            @(negedge pixel_clock);
            waited++;
        end
        check_equal("irq within one frame", irq, 1);
        read_line(line_a);
        checks++;
        assert (line_a == compare || line_a == next_line(compare)) else begin
            $display("FAIL t=%0t line %0d after irq, compare %0d", $time, line_a, compare);
            errors++;
        end
        bus_write(vic_pkg::reg_irq_latch, 8'h01);
        check_equal("irq after clear", irq, 0);
        bus_write(vic_pkg::reg_irq_enable, 8'h00);
        watch_outputs(frame_cycles, 4'h0, sync_count, blank_count, bkg_count, irq_count, longest);
        check_equal("irq cycles with enable clear", irq_count, 0);
        report_test("raster irq", errors_before);

        errors_before = errors;
        goto_line(100);
        watch_outputs(line_cycles, 4'h0, sync_count, blank_count, bkg_count, irq_count, longest);
        check_equal("sync cycles per line", sync_count,
                    int'(vic_pkg::hsync_clear - vic_pkg::hsync_set));
        check_equal("blank cycles per line", blank_count,
                    int'(vic_pkg::hblank_clear - vic_pkg::hblank_set));
        // Vertical blank opens and closes inside a horizontal blank
        watch_outputs(frame_cycles, 4'h0, sync_count, blank_count, bkg_count, irq_count, longest);
        check_equal("longest blank run", longest,
                    int'(vic_pkg::vblank_clear - vic_pkg::vblank_set) * line_cycles
                    + int'(vic_pkg::hblank_clear - vic_pkg::hblank_set));
        report_test("sync and blank", errors_before);

        errors_before = errors;
        exterior   = 4'($urandom);
        background = exterior + 4'(1 + $urandom % 15);   // Never equal to exterior
        bus_write(vic_pkg::reg_exterior, {4'h0, exterior});
        bus_write(vic_pkg::reg_bkg0, {4'h0, background});
        bus_write(vic_pkg::reg_ctrl1, 8'h18);           // Blank bit and 25 rows
        bus_write(vic_pkg::reg_ctrl2, 8'h08);           // 40 columns
        goto_line(2);
        goto_line(100);
        watch_outputs(line_cycles, background, sync_count, blank_count, bkg_count, irq_count,
                      longest);
        check_equal("background cycles, 40 columns", bkg_count,
                    int'(vic_pkg::bkde40_clear - vic_pkg::bkde40_set));
        bus_write(vic_pkg::reg_ctrl2, 8'h00);
        watch_outputs(line_cycles, background, sync_count, blank_count, bkg_count, irq_count,
                      longest);
        check_equal("background cycles, 38 columns", bkg_count,
                    int'(vic_pkg::bkde38_clear - vic_pkg::bkde38_set));
        bus_write(vic_pkg::reg_ctrl1, 8'h08);
        goto_line(2);                                   // Past the enable line
        watch_outputs(frame_cycles, background, sync_count, blank_count, bkg_count, irq_count,
                      longest);
        check_equal("background cycles, blank bit clear", bkg_count, 0);
        report_test("display window", errors_before);

        $display("tests %0d, checks %0d, failed %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* rtl/vic_top.sv */
// ==================================================
// Top level of the VIC-II style raster core.
// Joins the beam counter, the register bank and the
// timing decodes. CPU bus, interrupt, phi0 and the
// video outputs are plain ports.
// ==================================================
`timescale 1ns/1ps

module vic_top (
    input  logic        pixel_clock,
    input  logic        reset,
    input  logic        cs,
    input  logic        we,
    input  logic [5:0]  addr,
    input  logic [vic_pkg::data_width-1:0] data_in,
    output logic [vic_pkg::data_width-1:0] data_out,
    output logic        irq,
    output logic        phi0,
    output logic [vic_pkg::color_width-1:0] color,
    output logic        sync,
    output logic        blank
);

    beam_if         beam ();
    video_config_if video_config ();

    beam_counter u_beam_counter (
        .pixel_clock (pixel_clock),
        .reset       (reset),
        .beam        (beam.source),
        .phi0        (phi0)
    );

    register_file u_register_file (
        .pixel_clock  (pixel_clock),
        .reset        (reset),
        .cs           (cs),
        .we           (we),
        .addr         (addr),
        .data_in      (data_in),
        .data_out     (data_out),
        .irq          (irq),
        .beam         (beam.sink),
        .video_config (video_config.source)
    );

    video_timing u_video_timing (
        .pixel_clock  (pixel_clock),
        .reset        (reset),
        .beam         (beam.sink),
        .video_config (video_config.sink),
        .color        (color),
        .sync         (sync),
        .blank        (blank)
    );

endmodule

/* rtl/video_timing.sv */
// ==================================================
// Horizontal and vertical decodes of the raster core.
// Registers each window flag from the beam position,
// then forms composite sync, blank and the color
// index: background #0 inside the display window,
// exterior color outside it.
// ==================================================
`timescale 1ns/1ps

module video_timing (
    input  logic        pixel_clock,
    input  logic        reset,
    beam_if.sink        beam,
    video_config_if.sink video_config,
    output logic [vic_pkg::color_width-1:0] color,
    output logic        sync,
    output logic        blank
);

    logic hsync;
    logic hblank;
    logic heq1;
    logic heq2;
    logic bkde38;
    logic bkde40;
    logic vsync;
    logic veq;
    logic vblank;
    logic vsw24;
    logic vsw25;
    logic display_enable;
    logic column_window;
    logic row_window;

    // Flag goes high at set_at and low at clear_at
    function automatic logic next_flag(input logic state,
                                       input logic [8:0] count,
                                       input logic [8:0] set_at,
                                       input logic [8:0] clear_at);
        if (count == set_at) begin
            return 1'b1;
        end else if (count == clear_at) begin
            return 1'b0;
        end
        return state;
    endfunction

    always_ff @(posedge pixel_clock) begin
        if (reset) begin
            hsync          <= 1'b0;
            hblank         <= 1'b0;
            heq1           <= 1'b0;
            heq2           <= 1'b0;
            bkde38         <= 1'b0;
            bkde40         <= 1'b0;
            vsync          <= 1'b0;
            veq            <= 1'b0;
            vblank         <= 1'b0;
            vsw24          <= 1'b0;
            vsw25          <= 1'b0;
            display_enable <= 1'b0;
        end else begin
            hsync  <= next_flag(hsync, beam.xpos, vic_pkg::hsync_set, vic_pkg::hsync_clear);
            hblank <= next_flag(hblank, beam.xpos, vic_pkg::hblank_set, vic_pkg::hblank_clear);
            heq1   <= next_flag(heq1, beam.xpos, vic_pkg::heq1_set, vic_pkg::heq1_clear);
            heq2   <= next_flag(heq2, beam.xpos, vic_pkg::heq2_set, vic_pkg::heq2_clear);
            bkde38 <= next_flag(bkde38, beam.xpos, vic_pkg::bkde38_set, vic_pkg::bkde38_clear);
            bkde40 <= next_flag(bkde40, beam.xpos, vic_pkg::bkde40_set, vic_pkg::bkde40_clear);

            vsync  <= next_flag(vsync, beam.line, vic_pkg::vsync_set, vic_pkg::vsync_clear);
            veq    <= next_flag(veq, beam.line, vic_pkg::veq_set, vic_pkg::veq_clear);
            vblank <= next_flag(vblank, beam.line, vic_pkg::vblank_set, vic_pkg::vblank_clear);
            vsw24  <= next_flag(vsw24, beam.line, vic_pkg::vsw24_set, vic_pkg::vsw24_clear);
            vsw25  <= next_flag(vsw25, beam.line, vic_pkg::vsw25_set, vic_pkg::vsw25_clear);

            // Blank bit is sampled once per frame, entering the enable line
            if (beam.line_advance
                && (beam.line == vic_pkg::display_enable_line - 9'd1)) begin
                display_enable <= video_config.blank_bit;
            end
        end
    end

    assign column_window = video_config.column_select ? bkde40 : bkde38;
    assign row_window    = video_config.row_select ? vsw25 : vsw24;

    // Equalization pulses flip polarity inside vsync
    assign sync  = (hsync & ~vsync) | (veq & ((heq1 | heq2) ^ vsync));
    assign blank = hblank | vblank;
    assign color = (column_window && row_window && display_enable)
                   ? video_config.background_color
                   : video_config.exterior_color;

endmodule

/* rtl/register_file.sv */
// ==================================================
// CPU register bank of the raster core.
// Writes and reads act once per 8 pixels, on the
// access phase. Holds the raster compare value and
// the raster interrupt latch, and hands the picture
// fields to the timing unit.
// ==================================================
`timescale 1ns/1ps

module register_file (
    input  logic        pixel_clock,
    input  logic        reset,
    input  logic        cs,
    input  logic        we,
    input  logic [5:0]  addr,
    input  logic [vic_pkg::data_width-1:0] data_in,
    output logic [vic_pkg::data_width-1:0] data_out,
    output logic        irq,
    beam_if.sink        beam,
    video_config_if.source video_config
);

    logic [vic_pkg::data_width-1:0] regs [vic_pkg::reg_count];
    logic [vic_pkg::data_width-1:0] read_value;
    logic [vic_pkg::line_width-1:0] raster_compare;
    logic write_access;
    logic raster_enable;
    logic raster_hit;
    logic raster_latch;
    logic latch_clear;

    assign write_access   = beam.access_strobe && cs && we;
    assign raster_compare = {regs[vic_pkg::reg_ctrl1][7], regs[vic_pkg::reg_raster]};
    assign raster_enable  = regs[vic_pkg::reg_irq_enable][0];
    assign raster_hit     = beam.line_advance && raster_enable
                            && (beam.line == raster_compare);
    assign latch_clear    = write_access && (addr == vic_pkg::reg_irq_latch) && data_in[0];

    assign irq = raster_latch;  // Only the raster source exists

    // Fields used by the picture
    assign video_config.blank_bit        = regs[vic_pkg::reg_ctrl1][4];
    assign video_config.row_select       = regs[vic_pkg::reg_ctrl1][3];
    assign video_config.column_select    = regs[vic_pkg::reg_ctrl2][3];
    assign video_config.exterior_color   = regs[vic_pkg::reg_exterior][3:0];
    assign video_config.background_color = regs[vic_pkg::reg_bkg0][3:0];

    always_ff @(posedge pixel_clock) begin
        if (reset) begin
            for (int i = 0; i < vic_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_access && (addr < vic_pkg::reg_count)) begin
            regs[addr] <= data_in;
        end
    end

    // Unused bits read back as 1, the live raster replaces the compare value
    always_comb begin
        if (addr >= vic_pkg::reg_count) begin
            read_value = 8'hFF;                            // Unmapped
        end else if (addr >= vic_pkg::color_reg_first) begin
            read_value = {4'hF, regs[addr][3:0]};          // Color nibble only
        end else begin
            case (addr)
                vic_pkg::reg_ctrl1:
                    read_value = {beam.line[8], regs[addr][6:0]};
                vic_pkg::reg_raster:
                    read_value = beam.line[7:0];
                vic_pkg::reg_ctrl2:
                    read_value = {2'b11, regs[addr][5:0]};
                vic_pkg::reg_irq_latch:
                    read_value = {irq, 3'b111, 3'b000, raster_latch};
                vic_pkg::reg_irq_enable:
                    read_value = {4'hF, regs[addr][3:0]};
                default:
                    read_value = regs[addr];
            endcase
        end
    end

    always_ff @(posedge pixel_clock) begin
        if (reset) begin
            data_out <= '0;
        end else if (beam.access_strobe) begin
            data_out <= cs ? read_value : 8'h00;   // Held until the next access
        end
    end

    // A new raster match wins over a clear in the same cycle
    always_ff @(posedge pixel_clock) begin
        if (reset) begin
            raster_latch <= 1'b0;
        end else if (raster_hit) begin
            raster_latch <= 1'b1;
        end else if (latch_clear) begin
            raster_latch <= 1'b0;
        end
    end

endmodule

/* rtl/beam_counter.sv */
// ==================================================
// Beam position counter.
// Counts 504 pixels per line and 312 lines per frame,
// and derives the bus access strobe, the per-line
// advance pulse and the phi0 bus clock.
// ==================================================
`timescale 1ns/1ps

module beam_counter (
    input  logic   pixel_clock,
    input  logic   reset,
    beam_if.source beam,
    output logic   phi0
);

    logic [vic_pkg::xpos_width-1:0] xpos_count;
    logic [vic_pkg::line_width-1:0] line_count;
    logic [2:0] phase;

    assign phase = xpos_count[2:0];

    assign beam.xpos          = xpos_count;
    assign beam.line          = line_count;
    assign beam.access_strobe = (phase == vic_pkg::access_phase);
    assign beam.line_advance  = (xpos_count == vic_pkg::line_advance_x);
    assign beam.frame_wrap    = beam.line_advance
                                && (line_count == vic_pkg::lines_per_frame - 9'd1);

    always_ff @(posedge pixel_clock) begin
        if (reset) begin
            xpos_count <= '0;
            line_count <= '0;
            phi0       <= 1'b0;
        end else begin
            if (xpos_count == vic_pkg::pixels_per_line - 9'd1) begin
                xpos_count <= '0;
            end else begin
                xpos_count <= xpos_count + 9'd1;
            end

            if (beam.frame_wrap) begin
                line_count <= '0;              // Back to the top of the frame
            end else if (beam.line_advance) begin
                line_count <= line_count + 9'd1;
            end

            // Half high, half low over the 8 pixel cycle
            if (phase == vic_pkg::phi0_rise_phase) begin
                phi0 <= 1'b1;
            end else if (phase == vic_pkg::phi0_fall_phase) begin
                phi0 <= 1'b0;
            end
        end
    end

endmodule

/* rtl/vic_if.sv */
// ==================================================
// Internal bundles of the raster core.
// beam_if carries the beam position and its strobes
// from the counter to the other units.
// video_config_if carries the register fields that
// shape the picture into the timing unit.
// ==================================================
`timescale 1ns/1ps

interface beam_if;
    logic [vic_pkg::xpos_width-1:0] xpos;
    logic [vic_pkg::line_width-1:0] line;
    logic access_strobe;   // Bus phase of the 8 pixel cycle
    logic line_advance;    // One pulse per line
    logic frame_wrap;      // Advance out of the last line

    modport source (
        output xpos,
        output line,
        output access_strobe,
        output line_advance,
        output frame_wrap
    );

    modport sink (
        input xpos,
        input line,
        input access_strobe,
        input line_advance,
        input frame_wrap
    );
endinterface

interface video_config_if;
    logic blank_bit;       // DEN from control 1
    logic row_select;      // 25 rows when set
    logic column_select;   // 40 columns when set
    logic [vic_pkg::color_width-1:0] exterior_color;
    logic [vic_pkg::color_width-1:0] background_color;

    modport source (
        output blank_bit,
        output row_select,
        output column_select,
        output exterior_color,
        output background_color
    );

    modport sink (
        input blank_bit,
        input row_select,
        input column_select,
        input exterior_color,
        input background_color
    );
endinterface

/* rtl/vic_pkg.sv */
// ==================================================
// Shared constants for the VIC-II style raster core.
// Beam geometry, the set and clear points of every
// horizontal and vertical decode, and the CPU
// register map. Referenced as vic_pkg::name.
// ==================================================
package vic_pkg;

    // Beam geometry (PAL)
    localparam int xpos_width = 9;
    localparam int line_width = 9;
    localparam logic [8:0] pixels_per_line = 9'd504;
    localparam logic [8:0] lines_per_frame = 9'd312;
    localparam logic [2:0] access_phase    = 3'd4;     // Register bank acts here
    localparam logic [2:0] phi0_rise_phase = 3'd3;
    localparam logic [2:0] phi0_fall_phase = 3'd7;
    localparam logic [8:0] line_advance_x  = 9'd404;   // Vertical count steps here

    // Horizontal decodes, in pixels
    localparam logic [8:0] hsync_set    = 9'd400;
    localparam logic [8:0] hsync_clear  = 9'd436;
    localparam logic [8:0] hblank_set   = 9'd380;
    localparam logic [8:0] hblank_clear = 9'd480;
    localparam logic [8:0] heq1_set     = 9'd162;
    localparam logic [8:0] heq1_clear   = 9'd180;
    localparam logic [8:0] heq2_set     = 9'd418;
    localparam logic [8:0] heq2_clear   = 9'd436;
    localparam logic [8:0] bkde38_set   = 9'd26;      // 38 column window
    localparam logic [8:0] bkde38_clear = 9'd330;
    localparam logic [8:0] bkde40_set   = 9'd19;      // 40 column window
    localparam logic [8:0] bkde40_clear = 9'd339;

    // Vertical decodes, in lines
    localparam logic [8:0] vsync_set    = 9'd297;
    localparam logic [8:0] vsync_clear  = 9'd300;
    localparam logic [8:0] veq_set      = 9'd294;
    localparam logic [8:0] veq_clear    = 9'd303;
    localparam logic [8:0] vblank_set   = 9'd293;
    localparam logic [8:0] vblank_clear = 9'd304;
    localparam logic [8:0] vsw24_set    = 9'd55;      // 24 row window
    localparam logic [8:0] vsw24_clear  = 9'd247;
    localparam logic [8:0] vsw25_set    = 9'd51;      // 25 row window
    localparam logic [8:0] vsw25_clear  = 9'd251;
    localparam logic [8:0] display_enable_line = 9'd1;

    // Register map
    localparam logic [5:0] reg_ctrl1       = 6'h11;
    localparam logic [5:0] reg_raster      = 6'h12;
    localparam logic [5:0] reg_ctrl2       = 6'h16;
    localparam logic [5:0] reg_irq_latch   = 6'h19;
    localparam logic [5:0] reg_irq_enable  = 6'h1A;
    localparam logic [5:0] reg_exterior    = 6'h20;
    localparam logic [5:0] reg_bkg0        = 6'h21;
    localparam logic [5:0] color_reg_first = 6'h20;
    localparam logic [5:0] reg_count       = 6'd47;   // 0x00 to 0x2E

    // Bus and color widths
    localparam int color_width = 4;
    localparam int data_width  = 8;

endpackage
